// ==== Makefile ====
TOP := fp_stall_tracer_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
rtl/fp_trace_pkg.sv
rtl/fp_issue_if.sv
rtl/fp_issue_decode.sv
rtl/fp_producer_table.sv
rtl/fp_event_register.sv
rtl/fp_stall_tracer.sv
verif/tb_clock_gen.sv
verif/fp_stall_tracer_tb.sv

// ==== rtl/fp_event_register.sv ====
`timescale 1ns/10ps

module fp_event_register
    import fp_trace_pkg::*;
    (
        input  logic                    clk,
        input  logic                    rst,

        input  stall_class_t            stall,
        input  logic                    issued,
        input  logic [NUM_OPS-1:0]      op_mix,
        input  logic [NUM_OPS-1:0]      op_operand_stall,
        input  unit_vec_t               stall_source,
        input  logic [NUM_WB-1:0]       unit_pending_wb,
        input  logic                    commit_valid,
        input  logic [FLEN-1:0]         commit_data,
        input  logic [LOG2_MAX_IDS:0]   inflight_count,

        output fp_event_t               events,
        output logic [LOG2_MAX_IDS:0]   in_flight_ids
    );

    logic                   expo_zero;
    logic                   frac_nonzero;
    logic                   rd_subnormal;
    logic [LOG2_MAX_IDS:0]  ids_sat;
    fp_event_t              events_d;

    ////////////////////////////////////////////////////
    // subnormal commit and in-flight count

    // exponent sits just below the sign bit
    assign expo_zero    = ~|commit_data[FLEN-2 -: EXPO_W];
    assign frac_nonzero = |commit_data[FRAC_W-1:0];
    assign rd_subnormal = commit_valid & expo_zero & frac_nonzero;

    // top bit set means the counter has wrapped past the pool
    assign ids_sat = inflight_count[LOG2_MAX_IDS]
                     ? (LOG2_MAX_IDS+1)'(MAX_IDS)
                     : {1'b0, inflight_count[LOG2_MAX_IDS-1:0]};

    always_comb begin
        events_d.issued           = issued;
        events_d.stall            = stall;
        events_d.op_mix           = op_mix;
        events_d.op_operand_stall = op_operand_stall;
        events_d.stall_source     = stall_source;
        events_d.wb_stall         = unit_pending_wb;
        events_d.rd_subnormal     = rd_subnormal;
    end

    ////////////////////////////////////////////////////
    // output stage

    always_ff @(posedge clk) begin
        if (rst) begin
            events        <= '0;
            in_flight_ids <= '0;
        end else begin
            events        <= events_d;
            in_flight_ids <= ids_sat;
        end
    end

endmodule

// ==== rtl/fp_issue_decode.sv ====
`timescale 1ns/10ps

module fp_issue_decode
    import fp_trace_pkg::*;
    (
        input  logic                                stage_valid,
        input  logic                                is_float,
        input  fp_op_e                              op,
        input  logic                                instruction_issued,
        input  logic                                fetch_flush,
        input  logic                                issue_hold,
        input  logic                                operands_ready,
        input  logic                                pc_id_available,
        input  unit_vec_t                           unit_ready,
        input  logic                                rd_valid,
        input  logic [PHYS_ADDR_W-1:0]              rd_addr,
        input  logic [NUM_SRC-1:0][PHYS_ADDR_W-1:0] rs_addr,
        input  logic [NUM_SRC-1:0]                  rs_conflict,

        fp_issue_if.classifier                      issue,

        output stall_class_t                        stall,
        output logic                                issued,
        output logic [NUM_OPS-1:0]                  op_mix,
        output logic [NUM_OPS-1:0]                  op_operand_stall
    );

    fp_unit_e           needed_unit;
    logic               needed_ready;
    unit_vec_t          needed_onehot;
    logic [NUM_OPS-1:0] op_onehot;

    ////////////////////////////////////////////////////
    // unit lookup for the op in the issue stage

    assign needed_unit   = unit_of_op(op);
    assign needed_ready  = unit_ready[needed_unit];
    assign needed_onehot = unit_vec_t'(1) << needed_unit;
    assign op_onehot     = NUM_OPS'(1) << op;

    ////////////////////////////////////////////////////
    // stall categories

    always_comb begin
        // operands missing while the unit could take it
        stall.operand = stage_valid & is_float & ~fetch_flush & ~issue_hold
                        & ~operands_ready & needed_ready;

        // target unit busy
        stall.unit = stage_valid & is_float & ~fetch_flush & ~needed_ready;

        // every id is in the pipeline
        stall.no_id = ~stage_valid & ~pc_id_available & ~fetch_flush;

        // front end empty or being flushed
        stall.no_instruction = (~stage_valid & ~stall.no_id) | fetch_flush;

        stall.other = stage_valid & ~instruction_issued
                      & ~(stall.operand | stall.unit | stall.no_id | stall.no_instruction);
    end

    ////////////////////////////////////////////////////
    // per-op events

    assign issued           = instruction_issued & is_float;
    assign op_mix           = issued ? op_onehot : '0;
    assign op_operand_stall = stall.operand ? op_onehot : '0;

    ////////////////////////////////////////////////////
    // register info for the producer table

    assign issue.rd_write      = issued & rd_valid;
    assign issue.rd_addr       = rd_addr;
    assign issue.producer      = needed_onehot;
    assign issue.rs_addr       = rs_addr;
    assign issue.rs_conflict   = rs_conflict;
    assign issue.operand_stall = stall.operand;

endmodule

// ==== rtl/fp_issue_if.sv ====
`timescale 1ns/10ps

interface fp_issue_if
    import fp_trace_pkg::*;
    ();

    // fp instruction issued with a destination register
    logic                                   rd_write;
    logic [PHYS_ADDR_W-1:0]                 rd_addr;
    // one-hot unit that will write rd
    unit_vec_t                              producer;

    // source operands of the instruction in the issue stage
    logic [NUM_SRC-1:0][PHYS_ADDR_W-1:0]    rs_addr;
    logic [NUM_SRC-1:0]                     rs_conflict;
    logic                                   operand_stall;

    modport classifier (
        output rd_write,
        output rd_addr,
        output producer,
        output rs_addr,
        output rs_conflict,
        output operand_stall
    );

    modport prod_table (
        input rd_write,
        input rd_addr,
        input producer,
        input rs_addr,
        input rs_conflict,
        input operand_stall
    );

endinterface

// ==== rtl/fp_producer_table.sv ====
`timescale 1ns/10ps

module fp_producer_table
    import fp_trace_pkg::*;
    (
        input  logic                    clk,
        input  logic                    rst,

        fp_issue_if.prod_table          issue,

        input  logic                    commit_valid,
        input  logic [PHYS_ADDR_W-1:0]  commit_addr,

        output unit_vec_t               stall_source
    );

    // one-hot unit that will write each physical register and zero once committed
    unit_vec_t producer_q [PHYS_REGS];

    unit_vec_t conflict_units;

    ////////////////////////////////////////////////////
    // set on issue, clear on commit

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < PHYS_REGS; r++) begin
                producer_q[r] <= '0;
            end
        end else begin
            if (issue.rd_write) begin
                producer_q[issue.rd_addr] <= issue.producer;
            end
            // commit comes last so it wins on the same address
            if (commit_valid) begin
                producer_q[commit_addr] <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////
    // stall source lookup

    // units owning any conflicting source in the old table contents
    always_comb begin
        conflict_units = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            if (issue.rs_conflict[s]) begin
                conflict_units = conflict_units | producer_q[issue.rs_addr[s]];
            end
        end
    end

    assign stall_source = issue.operand_stall ? conflict_units : '0;

endmodule

// ==== rtl/fp_stall_tracer.sv ====
`timescale 1ns/10ps

module fp_stall_tracer
    import fp_trace_pkg::*;
    (
        input  logic                                clk,
        input  logic                                rst,

        // issue stage state
        input  logic                                stage_valid,
        input  logic                                is_float,
        input  fp_op_e                              op,
        input  logic                                instruction_issued,
        input  logic                                fetch_flush,
        input  logic                                issue_hold,
        input  logic                                operands_ready,
        input  logic                                pc_id_available,
        input  unit_vec_t                           unit_ready,
        input  logic                                rd_valid,
        input  logic [PHYS_ADDR_W-1:0]              rd_addr,
        input  logic [NUM_SRC-1:0][PHYS_ADDR_W-1:0] rs_addr,
        input  logic [NUM_SRC-1:0]                  rs_conflict,

        // commit and writeback
        input  logic                                commit_valid,
        input  logic [PHYS_ADDR_W-1:0]              commit_addr,
        input  logic [FLEN-1:0]                     commit_data,
        input  logic [NUM_WB-1:0]                   unit_pending_wb,
        input  logic [LOG2_MAX_IDS:0]               inflight_count,

        output fp_event_t                           events,
        output logic [LOG2_MAX_IDS:0]               in_flight_ids
    );

    stall_class_t       stall;
    logic               issued;
    logic [NUM_OPS-1:0] op_mix;
    logic [NUM_OPS-1:0] op_operand_stall;
    unit_vec_t          stall_source;

    fp_issue_if issue_bus ();

    ////////////////////////////////////////////////////
    // classify, track producers, register

    fp_issue_decode i_fp_issue_decode (
        .stage_valid        (stage_valid),
        .is_float           (is_float),
        .op                 (op),
        .instruction_issued (instruction_issued),
        .fetch_flush        (fetch_flush),
        .issue_hold         (issue_hold),
        .operands_ready     (operands_ready),
        .pc_id_available    (pc_id_available),
        .unit_ready         (unit_ready),
        .rd_valid           (rd_valid),
        .rd_addr            (rd_addr),
        .rs_addr            (rs_addr),
        .rs_conflict        (rs_conflict),
        .issue              (issue_bus.classifier),
        .stall              (stall),
        .issued             (issued),
        .op_mix             (op_mix),
        .op_operand_stall   (op_operand_stall)
    );

    fp_producer_table i_fp_producer_table (
        .clk                (clk),
        .rst                (rst),
        .issue              (issue_bus.prod_table),
        .commit_valid       (commit_valid),
        .commit_addr        (commit_addr),
        .stall_source       (stall_source)
    );

    fp_event_register i_fp_event_register (
        .clk                (clk),
        .rst                (rst),
        .stall              (stall),
        .issued             (issued),
        .op_mix             (op_mix),
        .op_operand_stall   (op_operand_stall),
        .stall_source       (stall_source),
        .unit_pending_wb    (unit_pending_wb),
        .commit_valid       (commit_valid),
        .commit_data        (commit_data),
        .inflight_count     (inflight_count),
        .events             (events),
        .in_flight_ids      (in_flight_ids)
    );

endmodule

// ==== rtl/fp_trace_pkg.sv ====
package fp_trace_pkg;

    ////////////////////////////////////////////////////
    // sizes

    // floating-point physical register file
    localparam int PHYS_REGS   = 64;
    localparam int PHYS_ADDR_W = 6;

    // committed single-precision data
    localparam int FLEN   = 32;
    localparam int EXPO_W = 8;
    localparam int FRAC_W = 23;

    // instruction id pool
    localparam int MAX_IDS      = 8;
    localparam int LOG2_MAX_IDS = 3;

    // rs1, rs2, rs3
    localparam int NUM_SRC = 3;

    ////////////////////////////////////////////////////
    // operation classes and units

    typedef enum logic [3:0] {
        FP_LOAD,
        FP_STORE,
        FP_FMADD,
        FP_FADD,
        FP_FMUL,
        FP_FDIV,
        FP_FSQRT,
        FP_FCVT,
        FP_FCMP,
        FP_MINMAX,
        FP_CLASS,
        FP_SIGNJ
    } fp_op_e;

    localparam int NUM_OPS = 12;

    // issue-side units where the value is the bit index in unit_vec_t
    typedef enum logic [2:0] {
        UNIT_FMADD,
        UNIT_FDIV_SQRT,
        UNIT_WB2FP,
        UNIT_WB2INT,
        UNIT_FLS
    } fp_unit_e;

    localparam int NUM_UNITS = 5;

    typedef logic [NUM_UNITS-1:0] unit_vec_t;

    // writeback ports where the value is the bit index in wb_stall
    typedef enum logic [1:0] {
        WB_FMADD,
        WB_FMUL,
        WB_FDIV_SQRT,
        WB_WB2FP
    } fp_wb_e;

    localparam int NUM_WB = 4;

    ////////////////////////////////////////////////////
    // event records

    typedef struct packed {
        logic operand;
        logic unit;
        logic no_id;
        logic no_instruction;
        logic other;
    } stall_class_t;

    typedef struct packed {
        logic                 issued;
        stall_class_t         stall;
        logic [NUM_OPS-1:0]   op_mix;
        logic [NUM_OPS-1:0]   op_operand_stall;
        unit_vec_t            stall_source;
        logic [NUM_WB-1:0]    wb_stall;
        logic                 rd_subnormal;
    } fp_event_t;

    // unit that executes and writes back each operation class
    function automatic fp_unit_e unit_of_op(input fp_op_e op);
        case (op)
            FP_LOAD, FP_STORE:           return UNIT_FLS;
            FP_FMADD, FP_FADD, FP_FMUL:  return UNIT_FMADD;
            FP_FDIV, FP_FSQRT:           return UNIT_FDIV_SQRT;
            FP_MINMAX, FP_SIGNJ:         return UNIT_WB2FP;
            FP_FCVT, FP_FCMP, FP_CLASS:  return UNIT_WB2INT;
            default:                     return UNIT_WB2INT;
        endcase
    endfunction

endpackage

// ==== verif/fp_stall_tracer_tb.sv ====
`timescale 1ns/10ps

module fp_stall_tracer_tb
    import fp_trace_pkg::*;
    ();

    localparam int WAIT_LIMIT = 20;
    localparam logic [PHYS_ADDR_W-1:0] TEST_REG = 6'd37;

    logic clk;
    logic rst;
    logic stage_valid, is_float, instruction_issued, fetch_flush;
    logic issue_hold, operands_ready, pc_id_available, rd_valid, commit_valid;
    fp_op_e                              op;
    unit_vec_t                           unit_ready;
    logic [PHYS_ADDR_W-1:0]              rd_addr, commit_addr;
    logic [NUM_SRC-1:0][PHYS_ADDR_W-1:0] rs_addr;
    logic [NUM_SRC-1:0]                  rs_conflict;
    logic [FLEN-1:0]                     commit_data;
    logic [NUM_WB-1:0]                   unit_pending_wb;
    logic [LOG2_MAX_IDS:0]               inflight_count, in_flight_ids, exp_ids;
    fp_event_t                           events, exp_events;

    // shadow of the producer table
    unit_vec_t   shadow [PHYS_REGS];
    logic [15:0] lfsr_state = 16'd21159;
    logic        idle_phase = 1'b1;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    tb_clock_gen i_clock_gen (.clk(clk));

    fp_stall_tracer i_fp_stall_tracer (.*);

    //////////////////////////////////////////////////
    // random source with taps x^16 + x^14 + x^13 + x^11 + 1

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] v;
        v = rand_bits(1);
        return v[0];
    endfunction

    //////////////////////////////////////////////////
    // reference model

    function automatic fp_unit_e unit_for_op(input fp_op_e o);
        case (o)
            FP_LOAD, FP_STORE:          return UNIT_FLS;
            FP_FMADD, FP_FADD, FP_FMUL: return UNIT_FMADD;
            FP_FDIV, FP_FSQRT:          return UNIT_FDIV_SQRT;
            FP_MINMAX, FP_SIGNJ:        return UNIT_WB2FP;
            default:                    return UNIT_WB2INT;
        endcase
    endfunction

    function automatic fp_event_t expected_events();
        fp_event_t e;
        logic      rdy;
        rdy = unit_ready[unit_for_op(op)];
        e = '0;
        e.stall.operand = stage_valid && is_float && !fetch_flush && !issue_hold
                          && !operands_ready && rdy;
        e.stall.unit = stage_valid && is_float && !fetch_flush && !rdy;
        e.stall.no_id = !stage_valid && !pc_id_available && !fetch_flush;
        e.stall.no_instruction = (!stage_valid && !e.stall.no_id) || fetch_flush;
        e.stall.other = stage_valid && !instruction_issued && !e.stall.operand
                        && !e.stall.unit && !e.stall.no_id && !e.stall.no_instruction;
        e.issued = instruction_issued && is_float;
        if (e.issued) begin
            e.op_mix[op] = 1'b1;
        end
        if (e.stall.operand) begin
            e.op_operand_stall[op] = 1'b1;
            for (int s = 0; s < NUM_SRC; s++) begin
                if (rs_conflict[s]) begin
                    e.stall_source = e.stall_source | shadow[rs_addr[s]];
                end
            end
        end
        e.wb_stall = unit_pending_wb;
        // exponent field above the 23 fraction bits
        e.rd_subnormal = commit_valid && (commit_data[FRAC_W +: EXPO_W] == '0)
                         && (commit_data[FRAC_W-1:0] != '0);
        return e;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < PHYS_REGS; r++) begin
                shadow[r] = '0;
            end
            exp_events <= '0;
            exp_ids    <= '0;
        end else begin
            exp_events <= expected_events();
            // count clipped at the size of the id pool
            if (inflight_count >= (LOG2_MAX_IDS+1)'(MAX_IDS)) begin
                exp_ids <= (LOG2_MAX_IDS+1)'(MAX_IDS);
            end else begin
                exp_ids <= inflight_count;
            end
            // table update after the read with commit last
            if (instruction_issued && is_float && rd_valid) begin
                shadow[rd_addr] = unit_vec_t'(1) << unit_for_op(op);
            end
            if (commit_valid) begin
                shadow[commit_addr] = '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // checks sampled mid-cycle

    a_events: assert property (@(negedge clk) disable iff (rst) events == exp_events)
        else begin
            errors++;
            $display("MISMATCH %0t: events %h, expected %h", $time, events, exp_events);
        end

    a_ids: assert property (@(negedge clk) disable iff (rst) in_flight_ids == exp_ids)
        else begin
            errors++;
            $display("MISMATCH %0t: in_flight_ids %0d, expected %0d", $time,
                     in_flight_ids, exp_ids);
        end

    a_idle: assert property (@(negedge clk) disable iff (rst)
                             idle_phase |-> (events == '0 && in_flight_ids == '0))
        else begin
            errors++;
            $display("MISMATCH %0t: outputs not zero after reset", $time);
        end

    a_stall_excl: assert property (@(negedge clk) disable iff (rst)
                                   $onehot0({events.stall.operand, events.stall.unit,
                                             events.stall.no_id}))
        else begin
            errors++;
            $display("MISMATCH %0t: more than one of operand, unit, no_id", $time);
        end

    a_op_onehot: assert property (@(negedge clk) disable iff (rst)
                                  $onehot0(events.op_mix) && $onehot0(events.op_operand_stall)
                                  && (events.issued || events.op_mix == '0))
        else begin
            errors++;
            $display("MISMATCH %0t: op_mix %b, op_operand_stall %b", $time,
                     events.op_mix, events.op_operand_stall);
        end

    //////////////////////////////////////////////////
    // stimulus

    // quiet issue stage with every event output inactive
    task automatic drive_idle();
        stage_valid        <= 1'b1;
        is_float           <= 1'b0;
        op                 <= FP_LOAD;
        instruction_issued <= 1'b1;
        fetch_flush        <= 1'b0;
        issue_hold         <= 1'b0;
        operands_ready     <= 1'b1;
        pc_id_available    <= 1'b1;
        unit_ready         <= '1;
        rd_valid           <= 1'b0;
        rd_addr            <= '0;
        rs_addr            <= '0;
        rs_conflict        <= '0;
        commit_valid       <= 1'b0;
        commit_addr        <= '0;
        commit_data        <= '0;
        unit_pending_wb    <= '0;
        inflight_count     <= '0;
    endtask

    // mode 0 anything, 1 float issue focus, 2 producer table focus
    task automatic drive_random(input int mode);
        logic [PHYS_ADDR_W-1:0] mask;
        mask = (mode == 2) ? 6'h07 : 6'h3f;
        @(posedge clk);
        stage_valid        <= (mode != 0) ? 1'b1 : rand_bit();
        is_float           <= (mode != 0) ? 1'b1 : rand_bit();
        op                 <= fp_op_e'(4'(rand_bits(4) % 12));
        instruction_issued <= rand_bit();
        fetch_flush        <= (mode != 0) ? 1'b0 : (rand_bits(2) == 0);
        issue_hold         <= (mode == 2) ? 1'b0 : rand_bit();
        operands_ready     <= rand_bit();
        pc_id_available    <= rand_bit();
        unit_ready         <= (mode == 2) ? '1 : unit_vec_t'(rand_bits(NUM_UNITS));
        rd_valid           <= (mode == 2) ? 1'b1 : rand_bit();
        rd_addr            <= PHYS_ADDR_W'(rand_bits(6)) & mask;
        for (int s = 0; s < NUM_SRC; s++) begin
            rs_addr[s] <= PHYS_ADDR_W'(rand_bits(6)) & mask;
        end
        rs_conflict        <= NUM_SRC'(rand_bits(3));
        commit_valid       <= rand_bit();
        commit_addr        <= PHYS_ADDR_W'(rand_bits(6)) & mask;
        commit_data        <= {rand_bit(), rand_bit() ? 8'h00 : 8'(rand_bits(8)),
                               23'(rand_bits(23))};
        unit_pending_wb    <= NUM_WB'(rand_bits(4));
        inflight_count     <= (LOG2_MAX_IDS+1)'(rand_bits(4));
    endtask

    task automatic issue_op(input fp_op_e o, input logic [PHYS_ADDR_W-1:0] r,
                            input logic also_commit);
        @(posedge clk);
        drive_idle();
        is_float     <= 1'b1;
        op           <= o;
        rd_valid     <= 1'b1;
        rd_addr      <= r;
        commit_valid <= also_commit;
        commit_addr  <= r;
    endtask

    task automatic commit_reg(input logic [PHYS_ADDR_W-1:0] r);
        @(posedge clk);
        drive_idle();
        commit_valid <= 1'b1;
        commit_addr  <= r;
    endtask

    // one cycle of operand stall with only source 2 in conflict
    task automatic present_stall(input logic [PHYS_ADDR_W-1:0] r);
        @(posedge clk);
        drive_idle();
        is_float           <= 1'b1;
        op                 <= FP_FADD;
        instruction_issued <= 1'b0;
        operands_ready     <= 1'b0;
        rs_addr            <= {r, r, r};
        rs_conflict        <= 3'b100;
        @(posedge clk);
        drive_idle();
    endtask

    task automatic check_stall_source(input unit_vec_t want);
        int n;
        n = 0;
        @(negedge clk);
        while (!events.stall.operand && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!events.stall.operand) begin
            errors++;
            $display("timeout: no operand stall reported within %0d cycles", WAIT_LIMIT);
        end else begin
            assert (events.stall_source == want)
                else begin
                    errors++;
                    $display("MISMATCH %0t: stall_source %b, expected %b", $time,
                             events.stall_source, want);
                end
        end
    endtask

    function automatic logic [FLEN-1:0] commit_pattern(input int k);
        case (k)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'h807f_ffff;
            3:       return 32'h3f80_0000;
            4:       return 32'h0080_0000;
            default: return 32'h7f80_0000;
        endcase
    endfunction

    // let the last driven cycle reach the outputs
    task automatic settle();
        @(posedge clk);
        drive_idle();
        @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    initial begin
        int start;
        rst <= 1'b1;
        drive_idle();
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        start = errors;
        repeat (4) @(negedge clk);
        @(posedge clk);
        idle_phase <= 1'b0;
        finish_test("reset", start);

        start = errors;
        repeat (400) drive_random(0);
        settle();
        finish_test("stall_class", start);

        start = errors;
        repeat (200) drive_random(1);
        settle();
        finish_test("op_mix", start);

        start = errors;
        issue_op(FP_FDIV, TEST_REG, 1'b0);
        present_stall(TEST_REG);
        check_stall_source(unit_vec_t'(1) << UNIT_FDIV_SQRT);
        commit_reg(TEST_REG);
        present_stall(TEST_REG);
        check_stall_source('0);
        // same-cycle issue and commit where the clear wins
        issue_op(FP_FSQRT, TEST_REG, 1'b1);
        present_stall(TEST_REG);
        check_stall_source('0);
        repeat (150) drive_random(2);
        settle();
        finish_test("producer_table", start);

        start = errors;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            drive_idle();
            commit_valid    <= (i % 4 != 3);
            commit_addr     <= 6'd63;
            commit_data     <= commit_pattern(i % 6);
            unit_pending_wb <= NUM_WB'(i);
            inflight_count  <= (LOG2_MAX_IDS+1)'(i);
        end
        settle();
        finish_test("wb_commit_ids", start);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule
